//--- source/cart_params.svh
`ifndef CART_PARAMS_SVH
`define CART_PARAMS_SVH

// ROM size as an address width, 16 gives 64 KB or eight 8 KB banks
`define CART_ROM_AW 16

// Request queue depth, also the credits the host holds after reset
`define CART_CREDITS 4

// Bank numbers after reset, one per 8 KB window 4000h to BFFFh
`define CART_BANK1_RST 8'd0
`define CART_BANK2_RST 8'd1
`define CART_BANK3_RST 8'd2
`define CART_BANK4_RST 8'd3

// Low six bits of a bank 3 write that switch the SCC on
`define CART_SCC_KEY 6'h3F

`endif

//--- source/cart_pkg.sv
package cart_pkg;

   // Host request opcodes
   typedef enum logic [1:0] {
      OP_READ  = 2'd0,  // CPU read through the mapper
      OP_WRITE = 2'd1,  // CPU write, bank switch or SCC register
      OP_LOAD  = 2'd2   // Fill ROM at the raw address
   } req_op_e;

   // Mapper configured for the cartridge
   typedef enum logic {
      MAPPER_NONE       = 1'b0,  // Nothing mapped, reads float
      MAPPER_KONAMI_SCC = 1'b1   // Konami SCC with four 8 KB banks
   } mapper_e;

   // Which device served a read
   typedef enum logic [1:0] {
      DEV_NONE = 2'd0,  // Open bus, data is FFh
      DEV_ROM  = 2'd1,
      DEV_SCC  = 2'd2
   } dev_e;

endpackage

//--- source/cart_bus_ctrl.sv
`timescale 1ns/1ps
`include "cart_params.svh"

module cart_bus_ctrl (
   input  logic                    clock_bus,
   input  logic                    reset,
   // Host request port
   input  logic                    req_valid,
   input  cart_pkg::req_op_e       req_op,
   input  logic                    req_slot,
   input  logic [15:0]             req_addr,
   input  logic [7:0]              req_data,
   output logic                    credit_return,
   // Mapper side
   output logic [15:0]             map_addr,
   output logic                    map_slot,
   output logic                    map_wr,
   output logic [7:0]              map_data,
   input  logic [`CART_ROM_AW-1:0] rom_addr,
   input  logic                    rom_hit,
   input  logic                    scc_hit,
   // ROM port
   output logic                    rd_en,
   output logic                    ld_en,
   output logic [`CART_ROM_AW-1:0] ld_addr,
   output logic [7:0]              ld_data,
   // SCC register port
   output logic                    scc_wr,
   output logic                    scc_rd,
   output logic [7:0]              scc_addr,
   output logic [7:0]              scc_wdata,
   // Read data back from the devices
   input  logic [7:0]              rom_rdata,
   input  logic [7:0]              scc_rdata,
   // Response port
   output logic                    rsp_valid,
   output logic [7:0]              rsp_data,
   output cart_pkg::dev_e          rsp_dev
);

   localparam int DEPTH = `CART_CREDITS;
   localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   // Queue payload, no reset needed
   cart_pkg::req_op_e q_op   [DEPTH];
   logic              q_slot [DEPTH];
   logic [15:0]       q_addr [DEPTH];
   logic [7:0]        q_data [DEPTH];

   logic [PW-1:0]     wr_ptr, rd_ptr;
   logic [PW:0]       count;
   logic              pop;
   logic              last_slot;       // Slot of the most recent removed entry
   cart_pkg::req_op_e head_op;
   logic              is_read;

   // Read tag stage, one cycle behind the removal
   logic              s1_valid;
   cart_pkg::dev_e    s1_dev;

   assign pop           = (count != '0);   // One entry leaves per cycle
   assign credit_return = pop;             // Credit goes back with each removal
   assign head_op       = q_op[rd_ptr];
   assign is_read       = pop && (head_op == cart_pkg::OP_READ);

   // Writes from the host, never more than DEPTH in flight
   always_ff @(posedge clock_bus) begin
      if (req_valid) begin
         q_op[wr_ptr]   <= req_op;
         q_slot[wr_ptr] <= req_slot;
         q_addr[wr_ptr] <= req_addr;
         q_data[wr_ptr] <= req_data;
      end
   end

   always_ff @(posedge clock_bus) begin
      if (reset) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         last_slot <= 1'b0;
      end else begin
         if (req_valid)
            wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop) begin
            rd_ptr    <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            last_slot <= q_slot[rd_ptr];
         end
         count <= count + (req_valid ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
      end
   end

   // Mapper decode of the head entry
   assign map_addr = q_addr[rd_ptr];
   assign map_slot = pop ? q_slot[rd_ptr] : last_slot;  // Hold slot for scc_active when idle
   assign map_data = q_data[rd_ptr];
   assign map_wr   = pop && (head_op == cart_pkg::OP_WRITE);

   // ROM port, load takes the raw address, read the mapped one
   assign ld_en   = pop && (head_op == cart_pkg::OP_LOAD);
   assign ld_addr = ld_en ? q_addr[rd_ptr][`CART_ROM_AW-1:0] : rom_addr;
   assign ld_data = q_data[rd_ptr];
   assign rd_en   = is_read && rom_hit;

   // SCC registers see the low byte, window mirrors every 256 bytes
   assign scc_addr  = q_addr[rd_ptr][7:0];
   assign scc_wdata = q_data[rd_ptr];
   assign scc_wr    = map_wr && scc_hit;
   assign scc_rd    = is_read && scc_hit;

   // Stage 1 records the device, stage 2 picks its data
   always_ff @(posedge clock_bus) begin
      if (reset) begin
         s1_valid  <= 1'b0;
         rsp_valid <= 1'b0;
      end else begin
         s1_valid  <= is_read;
         rsp_valid <= s1_valid;
      end
   end

   always_ff @(posedge clock_bus) begin
      if (rom_hit)
         s1_dev <= cart_pkg::DEV_ROM;
      else if (scc_hit)
         s1_dev <= cart_pkg::DEV_SCC;
      else
         s1_dev <= cart_pkg::DEV_NONE;   // Unmapped or mapper off
      rsp_dev <= s1_dev;
      case (s1_dev)
         cart_pkg::DEV_ROM: rsp_data <= rom_rdata;
         cart_pkg::DEV_SCC: rsp_data <= scc_rdata;
         default:           rsp_data <= 8'hFF;   // Open bus
      endcase
   end

endmodule

//--- source/mapper_konami_scc.sv
`timescale 1ns/1ps
`include "cart_params.svh"

module mapper_konami_scc (
   input  logic                    clock_bus,
   input  logic                    reset,
   input  cart_pkg::mapper_e       cfg_mapper,   // Static configuration
   input  logic [15:0]             map_addr,
   input  logic                    map_slot,
   input  logic                    map_wr,
   input  logic [7:0]              map_data,
   output logic [`CART_ROM_AW-1:0] rom_addr,
   output logic                    rom_hit,
   output logic                    scc_hit,
   output logic                    scc_active
);

   localparam int BW = `CART_ROM_AW - 13;   // Bank bits that fit the ROM

   logic [7:0] bank_reg [2][4];   // Per slot, banks 1 to 4
   logic [1:0] scc_en;            // SCC flag per slot
   logic       enabled;
   logic       in_window;
   logic [1:0] bank_sel;
   logic [7:0] bank_num;
   logic       bank_ok;

   assign enabled   = (cfg_mapper == cart_pkg::MAPPER_KONAMI_SCC);
   assign in_window = (map_addr >= 16'h4000) && (map_addr < 16'hC000);

   // 4000h maps to bank 1 ... A000h to bank 4
   assign bank_sel = map_addr[14:13] ^ 2'b10;

   // Bank switch writes land in the first 2 KB of each window
   always_ff @(posedge clock_bus) begin
      if (reset) begin
         for (int s = 0; s < 2; s++) begin
            bank_reg[s][0] <= `CART_BANK1_RST;
            bank_reg[s][1] <= `CART_BANK2_RST;
            bank_reg[s][2] <= `CART_BANK3_RST;
            bank_reg[s][3] <= `CART_BANK4_RST;
         end
         scc_en <= 2'b00;
      end else if (enabled && map_wr) begin
         case (map_addr[15:11])
            5'b01010: bank_reg[map_slot][0] <= map_data;   // 5000h
            5'b01110: bank_reg[map_slot][1] <= map_data;   // 7000h
            5'b10010: begin                                 // 9000h
               bank_reg[map_slot][2] <= map_data;
               // SCC key also lives here
               scc_en[map_slot] <= (map_data[5:0] == `CART_SCC_KEY);
            end
            5'b10110: bank_reg[map_slot][3] <= map_data;   // B000h
            default: ;
         endcase
      end
   end

   assign bank_num = bank_reg[map_slot][bank_sel];
   assign bank_ok  = ((bank_num >> BW) == 8'd0);   // Bank below ROM end

   // Bank number on top of the 8 KB offset
   assign rom_addr = {bank_num[BW-1:0], map_addr[12:0]};

   // SCC window 9800h to 9FFFh overrides the ROM
   assign scc_hit = enabled && scc_en[map_slot] && (map_addr[15:11] == 5'b10011);
   assign rom_hit = enabled && in_window && bank_ok && !scc_hit;

   assign scc_active = scc_en[map_slot];   // Follows the slot last addressed

endmodule

//--- source/scc_wave_regs.sv
`timescale 1ns/1ps

module scc_wave_regs (
   input  logic       clock_bus,
   input  logic       reset,
   input  logic       scc_wr,
   input  logic       scc_rd,
   input  logic [7:0] scc_addr,    // Mirrored every 256 bytes upstream
   input  logic [7:0] scc_wdata,
   output logic [7:0] scc_rdata,
   output logic [4:0] chan_en
);

   // Waveform RAM, four channels of 32 samples
   logic [7:0] wave [128];

   // 80h-89h frequency, 8Ah-8Eh volume, 8Fh channel enable
   logic [7:0] ctrl_regs [16];

   logic       wave_sel;
   logic       ctrl_sel;

   assign wave_sel = (scc_addr[7] == 1'b0);          // 00h-7Fh
   assign ctrl_sel = (scc_addr[7:4] == 4'h8);        // 80h-8Fh, 90h up ignored

   always_ff @(posedge clock_bus) begin
      if (reset) begin
         for (int i = 0; i < 128; i++)
            wave[i] <= 8'h00;
         for (int i = 0; i < 16; i++)
            ctrl_regs[i] <= 8'h00;
      end else if (scc_wr) begin
         if (wave_sel)
            wave[scc_addr[6:0]] <= scc_wdata;
         else if (ctrl_sel)
            ctrl_regs[scc_addr[3:0]] <= scc_wdata;
      end
   end

   // Only waveform bytes read back, the rest floats high
   always_ff @(posedge clock_bus) begin
      if (scc_rd)
         scc_rdata <= wave_sel ? wave[scc_addr[6:0]] : 8'hFF;
   end

   assign chan_en = ctrl_regs[15][4:0];   // One bit per channel

endmodule

//--- source/rom_store.sv
`timescale 1ns/1ps
`include "cart_params.svh"

module rom_store (
   input  logic                    clock_bus,
   input  logic                    ld_en,
   input  logic [`CART_ROM_AW-1:0] ld_addr,
   input  logic [7:0]              ld_data,
   input  logic                    rd_en,
   input  logic [`CART_ROM_AW-1:0] rom_addr,
   output logic [7:0]              rom_rdata
);

   // Cartridge image, filled by host loads
   logic [7:0] mem [2**`CART_ROM_AW];

   always_ff @(posedge clock_bus) begin
      if (ld_en)
         mem[ld_addr] <= ld_data;
   end

   // Registered read, data one cycle after rd_en
   always_ff @(posedge clock_bus) begin
      if (rd_en)
         rom_rdata <= mem[rom_addr];
   end

endmodule

//--- source/cart_slot_top.sv
`timescale 1ns/1ps
`include "cart_params.svh"

module cart_slot_top (
   input  logic              clock_bus,
   input  logic              reset,
   input  cart_pkg::mapper_e cfg_mapper,
   input  logic              req_valid,
   input  cart_pkg::req_op_e req_op,
   input  logic              req_slot,
   input  logic [15:0]       req_addr,
   input  logic [7:0]        req_data,
   output logic              credit_return,
   output logic              rsp_valid,
   output logic [7:0]        rsp_data,
   output cart_pkg::dev_e    rsp_dev,
   output logic              scc_active,
   output logic [4:0]        scc_chan_en
);

   logic [15:0]             map_addr;
   logic                    map_slot;
   logic                    map_wr;
   logic [7:0]              map_data;
   logic [`CART_ROM_AW-1:0] rom_addr;      // Mapped address from the mapper
   logic                    rom_hit;
   logic                    scc_hit;
   logic                    rd_en;
   logic                    ld_en;
   logic [`CART_ROM_AW-1:0] rom_port_addr; // ROM port address, load or read
   logic [7:0]              ld_data;
   logic                    scc_wr;
   logic                    scc_rd;
   logic [7:0]              scc_addr;
   logic [7:0]              scc_wdata;
   logic [7:0]              rom_rdata;
   logic [7:0]              scc_rdata;

   cart_bus_ctrl u_ctrl (
      .clock_bus     (clock_bus),
      .reset         (reset),
      .req_valid     (req_valid),
      .req_op        (req_op),
      .req_slot      (req_slot),
      .req_addr      (req_addr),
      .req_data      (req_data),
      .credit_return (credit_return),
      .map_addr      (map_addr),
      .map_slot      (map_slot),
      .map_wr        (map_wr),
      .map_data      (map_data),
      .rom_addr      (rom_addr),
      .rom_hit       (rom_hit),
      .scc_hit       (scc_hit),
      .rd_en         (rd_en),
      .ld_en         (ld_en),
      .ld_addr       (rom_port_addr),
      .ld_data       (ld_data),
      .scc_wr        (scc_wr),
      .scc_rd        (scc_rd),
      .scc_addr      (scc_addr),
      .scc_wdata     (scc_wdata),
      .rom_rdata     (rom_rdata),
      .scc_rdata     (scc_rdata),
      .rsp_valid     (rsp_valid),
      .rsp_data      (rsp_data),
      .rsp_dev       (rsp_dev)
   );

   mapper_konami_scc u_mapper (
      .clock_bus  (clock_bus),
      .reset      (reset),
      .cfg_mapper (cfg_mapper),
      .map_addr   (map_addr),
      .map_slot   (map_slot),
      .map_wr     (map_wr),
      .map_data   (map_data),
      .rom_addr   (rom_addr),
      .rom_hit    (rom_hit),
      .scc_hit    (scc_hit),
      .scc_active (scc_active)
   );

   scc_wave_regs u_scc (
      .clock_bus (clock_bus),
      .reset     (reset),
      .scc_wr    (scc_wr),
      .scc_rd    (scc_rd),
      .scc_addr  (scc_addr),
      .scc_wdata (scc_wdata),
      .scc_rdata (scc_rdata),
      .chan_en   (scc_chan_en)
   );

   // Single ROM port owned by the control block
   rom_store u_rom (
      .clock_bus (clock_bus),
      .ld_en     (ld_en),
      .ld_addr   (rom_port_addr),
      .ld_data   (ld_data),
      .rd_en     (rd_en),
      .rom_addr  (rom_port_addr),
      .rom_rdata (rom_rdata)
   );

endmodule

//--- testbench/tb_cart_slot.sv
`timescale 1ns/1ps
`include "cart_params.svh"

module tb_cart_slot;

   localparam int CREDITS    = `CART_CREDITS;
   localparam int NUM_BANKS  = 2 ** (`CART_ROM_AW - 13);   // 8 KB banks in the ROM
   localparam int WAIT_LIMIT = 200;                        // Cycles any one wait may take

   logic              clock_bus;
   logic              reset;
   cart_pkg::mapper_e cfg_mapper;
   logic              req_valid;
   cart_pkg::req_op_e req_op;
   logic              req_slot;
   logic [15:0]       req_addr;
   logic [7:0]        req_data;
   logic              credit_return;
   logic              rsp_valid;
   logic [7:0]        rsp_data;
   cart_pkg::dev_e    rsp_dev;
   logic              scc_active;
   logic [4:0]        scc_chan_en;   // SCC channel enable register

   // Reference state of the cartridge
   logic [7:0]  rom_model [2**`CART_ROM_AW];
   logic [7:0]  bank_model [2][4];
   logic        scc_flag_model [2];
   logic [7:0]  wave_model [128];
   logic [4:0]  chan_en_model;
   logic [9:0]  exp_q [$];          // {dev, data} for each read in flight
   logic [31:0] rng_state;
   int          credits;            // Host side credit count
   int          sent;
   int          credit_pulses;
   int          last_slot;
   int          mismatch_errors;
   int          other_errors;

   cart_slot_top dut_i (.*);

   initial begin
      clock_bus = 1'b0;
      forever #2 clock_bus = ~clock_bus;   // 4 ns period
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // Address in the SCC window through a random 256-byte mirror
   function automatic logic [15:0] scc_window(input logic [7:0] off);
      logic [31:0] r;
      r = next_rand();
      return {5'b10011, r[2:0], off};
   endfunction

   // Expected device and data for a CPU read
   function automatic logic [9:0] expected_read(input int slot, input logic [15:0] addr);
      int         win;
      logic [7:0] bank;
      if (cfg_mapper != cart_pkg::MAPPER_KONAMI_SCC)
         return {cart_pkg::DEV_NONE, 8'hFF};   // Mapper off, open bus
      if (scc_flag_model[slot] && addr >= 16'h9800 && addr <= 16'h9FFF) begin
         if (addr[7:0] < 8'h80)
            return {cart_pkg::DEV_SCC, wave_model[addr[6:0]]};
         return {cart_pkg::DEV_SCC, 8'hFF};    // Write-only registers
      end
      if (addr < 16'h4000 || addr > 16'hBFFF)
         return {cart_pkg::DEV_NONE, 8'hFF};
      win  = (int'(addr) - 'h4000) / 'h2000;
      bank = bank_model[slot][win];
      if (int'(bank) >= NUM_BANKS)
         return {cart_pkg::DEV_NONE, 8'hFF};   // Bank past the ROM end
      return {cart_pkg::DEV_ROM, rom_model[int'(bank) * 'h2000 + int'(addr[12:0])]};
   endfunction

   // CPU write as seen by the mapper and the SCC
   function automatic void model_write(input int slot, input logic [15:0] addr,
                                       input logic [7:0] data);
      if (cfg_mapper != cart_pkg::MAPPER_KONAMI_SCC)
         return;
      if (scc_flag_model[slot] && addr >= 16'h9800 && addr <= 16'h9FFF) begin
         if (addr[7:0] < 8'h80)
            wave_model[addr[6:0]] = data;
         else if (addr[7:0] == 8'h8F)
            chan_en_model = data[4:0];         // One bit per channel
      end
      case (addr & 16'hF800)                   // 2 KB switch windows
         16'h5000: bank_model[slot][0] = data;
         16'h7000: bank_model[slot][1] = data;
         16'h9000: begin
            bank_model[slot][2]  = data;
            scc_flag_model[slot] = (data[5:0] == `CART_SCC_KEY);
         end
         16'hB000: bank_model[slot][3] = data;
         default: ;
      endcase
   endfunction

   task automatic finish_run();
      $display("errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
      if (mismatch_errors == 0 && other_errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   endtask

   task automatic timeout_abort(input string what);
      $display("timeout while waiting for %s", what);
      other_errors++;
      finish_run();
   endtask

   // One falling edge, credits counted here only
   task automatic next_cycle();
      @(negedge clock_bus);
      req_valid = 1'b0;
      if (credit_return) begin
         credits++;
         credit_pulses++;
      end
      assert (credits <= CREDITS) else begin
         $display("host holds %0d credits, more than %0d", credits, CREDITS);
         other_errors++;
      end
   endtask

   task automatic send(input cart_pkg::req_op_e op, input int slot,
                       input logic [15:0] addr, input logic [7:0] data);
      int waited;
      waited = 0;
      next_cycle();
      while (credits == 0) begin
         if (waited == WAIT_LIMIT)
            timeout_abort("a credit");
         next_cycle();
         waited++;
      end
      req_valid = 1'b1;
      req_op    = op;
      req_slot  = slot[0];
      req_addr  = addr;
      req_data  = data;
      credits--;
      sent++;
      last_slot = slot;
      case (op)
         cart_pkg::OP_READ:  exp_q.push_back(expected_read(slot, addr));
         cart_pkg::OP_WRITE: model_write(slot, addr, data);
         default:            rom_model[addr] = data;   // Load at the raw address
      endcase
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      next_cycle();
      while (credits != CREDITS || exp_q.size() != 0) begin
         if (waited == WAIT_LIMIT)
            timeout_abort("the queue to drain");
         next_cycle();
         waited++;
      end
   endtask

   // Reads across all four windows in both slots, plus open-bus areas
   task automatic read_sweep(input int per_win);
      for (int s = 0; s < 2; s++) begin
         for (int w = 0; w < 4; w++)
            for (int k = 0; k < per_win; k++)
               send(cart_pkg::OP_READ, s, 16'h4000 + {w[1:0], 13'(next_rand())}, 8'h00);
         send(cart_pkg::OP_READ, s, 16'h0000, 8'h00);
         send(cart_pkg::OP_READ, s, 16'hC000 + 16'(next_rand() & 32'h3FFF), 8'h00);
      end
   endtask

   // Flag and register writes land at the edge after the last removal
   task automatic check_status();
      next_cycle();
      assert (scc_active == scc_flag_model[last_slot]) else begin
         $display("mismatch scc_active: got %0h, expected %0h",
                  scc_active, scc_flag_model[last_slot]);
         mismatch_errors++;
      end
      assert (scc_chan_en == chan_en_model) else begin
         $display("mismatch scc_chan_en: got %02h, expected %02h",
                  scc_chan_en, chan_en_model);
         mismatch_errors++;
      end
   endtask

   // Response checker, outputs are stable at the falling edge
   initial begin
      logic [9:0] exp;
      forever begin
         @(negedge clock_bus);
         if (!reset && rsp_valid) begin
            assert (exp_q.size() != 0) else begin
               $display("response arrived with no read outstanding");
               other_errors++;
            end
            if (exp_q.size() != 0) begin
               exp = exp_q.pop_front();
               assert (rsp_data == exp[7:0]) else begin
                  $display("mismatch rsp_data: got %02h, expected %02h", rsp_data, exp[7:0]);
                  mismatch_errors++;
               end
               assert (rsp_dev == exp[9:8]) else begin
                  $display("mismatch rsp_dev: got %0h, expected %0h", rsp_dev, exp[9:8]);
                  mismatch_errors++;
               end
            end
         end
      end
   end

   initial begin
      logic [31:0] r;
      logic [7:0]  off;
      int          lat;
      rng_state       = 32'd24;
      credits         = CREDITS;
      sent            = 0;
      credit_pulses   = 0;
      last_slot       = 0;
      mismatch_errors = 0;
      other_errors    = 0;
      reset      = 1'b1;
      cfg_mapper = cart_pkg::MAPPER_KONAMI_SCC;
      req_valid  = 1'b0;
      req_op     = cart_pkg::OP_READ;
      req_slot   = 1'b0;
      req_addr   = 16'h0000;
      req_data   = 8'h00;
      for (int s = 0; s < 2; s++) begin
         bank_model[s][0]  = `CART_BANK1_RST;
         bank_model[s][1]  = `CART_BANK2_RST;
         bank_model[s][2]  = `CART_BANK3_RST;
         bank_model[s][3]  = `CART_BANK4_RST;
         scc_flag_model[s] = 1'b0;
      end
      for (int i = 0; i < 128; i++)
         wave_model[i] = 8'h00;
      chan_en_model = 5'h00;
      repeat (10) @(posedge clock_bus);
      @(negedge clock_bus);
      reset = 1'b0;
      assert (!rsp_valid && !credit_return && !scc_active) else begin
         $display("response, credit or SCC status not low after reset");
         other_errors++;
      end

      for (int a = 0; a < 2**`CART_ROM_AW; a++)   // Whole ROM image from the generator
         send(cart_pkg::OP_LOAD, 0, 16'(a), 8'(next_rand()));
      read_sweep(4);                               // Reset banks 0 to 3
      drain();

      send(cart_pkg::OP_WRITE, 0, 16'h5000, 8'd4);
      send(cart_pkg::OP_WRITE, 0, 16'h7400, 8'd5);  // Inside the 2 KB window
      send(cart_pkg::OP_WRITE, 0, 16'h9000, 8'd6);
      send(cart_pkg::OP_WRITE, 0, 16'hB7FF, 8'd7);
      send(cart_pkg::OP_WRITE, 1, 16'h7000, 8'd9);  // Past the ROM end
      read_sweep(3);
      drain();

      send(cart_pkg::OP_WRITE, 1, 16'h9000, 8'h3F); // SCC on in slot 1
      drain();
      check_status();
      for (int k = 0; k < 16; k++) begin
         off = 8'(next_rand() & 32'h7F);
         send(cart_pkg::OP_WRITE, 1, scc_window(off), 8'(next_rand()));
         send(cart_pkg::OP_READ, 1, scc_window(off), 8'h00);
      end
      for (int k = 0; k < 8; k++)
         send(cart_pkg::OP_READ, 1, scc_window(8'h80 | 8'(next_rand())), 8'h00);
      send(cart_pkg::OP_WRITE, 1, scc_window(8'h8F), 8'(next_rand()));  // Channel enable
      send(cart_pkg::OP_READ, 0, 16'h9855, 8'h00);  // Slot 0 still sees ROM here
      send(cart_pkg::OP_READ, 1, 16'h8100, 8'h00);  // Bank 3Fh is unmapped
      drain();
      check_status();
      send(cart_pkg::OP_WRITE, 1, 16'h9000, 8'h02); // SCC off again
      drain();
      check_status();
      for (int k = 0; k < 6; k++)
         send(cart_pkg::OP_READ, 1, scc_window(8'(next_rand())), 8'h00);
      drain();

      send(cart_pkg::OP_READ, 0, 16'h6123, 8'h00);  // Latency from an empty queue
      next_cycle();
      lat = 1;
      while (!rsp_valid) begin
         if (lat == WAIT_LIMIT)
            timeout_abort("a read response");
         next_cycle();
         lat++;
      end
      assert (lat == 3) else begin
         $display("read answered %0d cycles after acceptance instead of 3", lat);
         other_errors++;
      end
      drain();

      for (int k = 0; k < 200; k++) begin           // Random burst at full credit rate
         r = next_rand();
         if (r[3:1] == 3'd0)
            send(cart_pkg::OP_WRITE, int'(r[0]), 16'h5000 + {r[5:4], 13'h0},
                 r[10] ? 8'h3F : {4'h0, r[9:6]});
         else if (r[3:1] == 3'd1)
            send(cart_pkg::OP_WRITE, int'(r[0]), 16'h9800 | {8'h00, r[23:16]}, r[31:24]);
         else if (r[3:1] == 3'd2)
            send(cart_pkg::OP_READ, int'(r[0]), 16'h9800 | {8'h00, r[23:16]}, 8'h00);
         else
            send(cart_pkg::OP_READ, int'(r[0]), 16'h4000 + {1'b0, r[30:16]}, 8'h00);
      end
      drain();
      check_status();

      next_cycle();
      cfg_mapper = cart_pkg::MAPPER_NONE;           // Mapper off, all reads float
      send(cart_pkg::OP_WRITE, 0, 16'h9000, 8'h3F);
      read_sweep(2);
      drain();
      check_status();

      assert (credit_pulses == sent) else begin
         $display("%0d credit returns for %0d requests", credit_pulses, sent);
         other_errors++;
      end
      finish_run();
   end

endmodule

//--- tb.f
+incdir+source
source/cart_pkg.sv
source/cart_bus_ctrl.sv
source/mapper_konami_scc.sv
source/scc_wave_regs.sv
source/rom_store.sv
source/cart_slot_top.sv
testbench/tb_cart_slot.sv

//--- Makefile
# Verilator build and run for the cartridge slot testbench

VERILATOR  ?= verilator
TOP        ?= tb_cart_slot
RTL_TOP    ?= cart_slot_top
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) source/cart_params.svh $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG) || ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
